//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = uart_io_tb
FILE_LIST = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/uart_byte_if.sv
`timescale 1ns/100ps

interface uart_byte_if;
    import uart_io_pkg::*;

    // Transmit stream into the serializer
    byte_t tx_data;
    logic  tx_valid;
    logic  tx_ready;

    // Receive stream out of the holding buffer
    byte_t rx_data;
    logic  rx_valid;
    logic  rx_ready;

    modport bridge (
        output tx_data, tx_valid, rx_ready,
        input  tx_ready, rx_data, rx_valid
    );

    modport transmitter (
        input  tx_data, tx_valid,
        output tx_ready
    );

    modport receiver (
        output rx_data, rx_valid,
        input  rx_ready
    );

endinterface

//--- hdl/uart_io_pkg.sv
package uart_io_pkg;

    //----------------------------------------
    // Bus and payload types
    //----------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    //----------------------------------------
    // Register map
    //----------------------------------------
    localparam word_t STATUS_ADDR  = 32'h8000_0000;
    localparam word_t RX_DATA_ADDR = 32'h8000_0004;
    localparam word_t TX_DATA_ADDR = 32'h8000_0008;

    // Low two bits pick a byte lane and take no part in decode
    localparam word_t ADDR_WORD_MASK = 32'hFFFF_FFFC;

    // Status word bit positions
    localparam int STATUS_TX_READY_BIT = 0;
    localparam int STATUS_RX_VALID_BIT = 1;

    //----------------------------------------
    // Serial bit timing
    //----------------------------------------
    localparam int CLOCKS_PER_BIT = 8;

    // Wide enough to hold CLOCKS_PER_BIT itself
    typedef logic [$clog2(CLOCKS_PER_BIT + 1) - 1:0] bit_count_t;

endpackage

//--- hdl/uart_io_top.sv
`timescale 1ns/100ps

module uart_io_top (
    input  logic               Clock,
    input  logic               reset,
    input  uart_io_pkg::word_t addr,
    input  uart_io_pkg::word_t write_data,
    input  logic               io_write,
    input  logic               io_read,
    output uart_io_pkg::word_t read_data,
    input  logic               serial_in,
    output logic               serial_out
);

    // Both byte streams in one bundle
    uart_byte_if bytes ();

    //----------------------------------------
    // Bus side
    //----------------------------------------
    uart_mmio_bridge i_uart_mmio_bridge (
        .Clock      (Clock),
        .reset      (reset),
        .addr       (addr),
        .write_data (write_data),
        .io_write   (io_write),
        .io_read    (io_read),
        .read_data  (read_data),
        .bytes      (bytes.bridge)
    );

    //----------------------------------------
    // Serial side
    //----------------------------------------
    uart_transmitter i_uart_transmitter (
        .Clock      (Clock),
        .reset      (reset),
        .bytes      (bytes.transmitter),
        .serial_out (serial_out)
    );

    // Line input is asynchronous to Clock
    uart_receiver i_uart_receiver (
        .Clock     (Clock),
        .reset     (reset),
        .serial_in (serial_in),
        .bytes     (bytes.receiver)
    );

endmodule

//--- hdl/uart_mmio_bridge.sv
`timescale 1ns/100ps

module uart_mmio_bridge (
    input  logic               Clock,
    input  logic               reset,
    input  uart_io_pkg::word_t addr,
    input  uart_io_pkg::word_t write_data,
    input  logic               io_write,
    input  logic               io_read,
    output uart_io_pkg::word_t read_data,
    uart_byte_if.bridge        bytes
);
    import uart_io_pkg::*;

    word_t word_addr;
    logic  rx_sel;
    logic  tx_sel;
    word_t status_word;
    word_t read_next;

    //----------------------------------------
    // Address decode
    //----------------------------------------
    assign word_addr = addr & ADDR_WORD_MASK;
    assign rx_sel    = (word_addr == RX_DATA_ADDR);
    assign tx_sel    = (word_addr == TX_DATA_ADDR);

    //----------------------------------------
    // Transmit path
    //----------------------------------------
    // Byte offset picks the lane of the store word
    always_comb
    begin
        case (addr[1:0])
            2'b00:
                bytes.tx_data = write_data[7:0];
            2'b01:
                bytes.tx_data = write_data[15:8];
            2'b10:
                bytes.tx_data = write_data[23:16];
            2'b11:
                bytes.tx_data = write_data[31:24];
        endcase
    end

    // Write while busy is dropped, software polls status first
    assign bytes.tx_valid = io_write && tx_sel && bytes.tx_ready;

    //----------------------------------------
    // Receive path
    //----------------------------------------
    // Pop only when a byte is actually held
    assign bytes.rx_ready = io_read && rx_sel && bytes.rx_valid;

    always_comb
    begin
        status_word = '0;
        status_word[STATUS_TX_READY_BIT] = bytes.tx_ready;
        status_word[STATUS_RX_VALID_BIT] = bytes.rx_valid;
    end

    // Unmapped reads and empty-buffer reads give zero
    always_comb
    begin
        case (word_addr)
            STATUS_ADDR:
                read_next = status_word;
            RX_DATA_ADDR:
            begin
                if (bytes.rx_valid)
                    read_next = {24'b0, bytes.rx_data};
                else
                    read_next = '0;
            end
            default:
                read_next = '0;
        endcase
    end

    //----------------------------------------
    // Registered read data
    //----------------------------------------
    // Holds its value between reads
    always_ff @(posedge Clock)
    begin
        if (reset)
            read_data <= '0;
        else if (io_read)
            read_data <= read_next;
    end

endmodule

//--- hdl/uart_receiver.sv
`timescale 1ns/100ps

module uart_receiver (
    input  logic          Clock,
    input  logic          reset,
    input  logic          serial_in,
    uart_byte_if.receiver bytes
);
    import uart_io_pkg::*;

    typedef enum logic [1:0] {
        state_idle,
        state_start,
        state_data,
        state_stop
    } rx_state_t;

    logic [1:0] sync_reg;
    logic       line;
    logic       line_prev;
    logic       start_edge;
    rx_state_t  state;
    bit_count_t clock_count;
    logic [2:0] bit_index;
    byte_t      shift_reg;
    byte_t      hold_data;
    logic       hold_valid;
    logic       mid_start;
    logic       bit_done;
    logic       frame_ok;

    assign line       = sync_reg[1];
    assign start_edge = line_prev & ~line;

    // Start bit is checked halfway, later bits one full period apart
    assign mid_start = (clock_count == bit_count_t'(CLOCKS_PER_BIT / 2 - 1));
    assign bit_done  = (clock_count == bit_count_t'(CLOCKS_PER_BIT - 1));

    // Good stop bit seen at its sample point
    assign frame_ok = (state == state_stop) && bit_done && line;

    assign bytes.rx_data  = hold_data;
    assign bytes.rx_valid = hold_valid;

    //----------------------------------------
    // Input synchronizer
    //----------------------------------------
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            sync_reg  <= 2'b11;
            line_prev <= 1'b1;
        end
        else
        begin
            sync_reg  <= {sync_reg[0], serial_in};
            line_prev <= line;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (reset || state == state_idle || (state == state_start && mid_start) || bit_done)
            clock_count <= '0;
        else
            clock_count <= clock_count + 1'b1;
    end

    //----------------------------------------
    // Frame sequencing
    //----------------------------------------
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state     <= state_idle;
            bit_index <= '0;
        end
        else
        begin
            case (state)
                state_idle:
                begin
                    if (start_edge)
                        state <= state_start;
                end
                state_start:
                begin
                    // A glitch that is high again by mid-bit is ignored
                    if (mid_start)
                    begin
                        state     <= line ? state_idle : state_data;
                        bit_index <= '0;
                    end
                end
                state_data:
                begin
                    if (bit_done)
                    begin
                        if (bit_index == 3'd7)
                            state <= state_stop;
                        bit_index <= bit_index + 1'b1;
                    end
                end
                state_stop:
                begin
                    if (bit_done)
                        state <= state_idle;
                end
                default:
                    state <= state_idle;
            endcase
        end
    end

    always_ff @(posedge Clock)
    begin
        if (state == state_data && bit_done)
            shift_reg <= {line, shift_reg[7:1]};
    end

    //----------------------------------------
    // One-byte holding buffer
    //----------------------------------------
    always_ff @(posedge Clock)
    begin
        if (reset)
            hold_valid <= 1'b0;
        else if (frame_ok && !hold_valid)
            hold_valid <= 1'b1;
        else if (hold_valid && bytes.rx_ready)
            hold_valid <= 1'b0;
    end

    // Frames arriving while full are lost
    always_ff @(posedge Clock)
    begin
        if (frame_ok && !hold_valid)
            hold_data <= shift_reg;
    end

endmodule

//--- hdl/uart_transmitter.sv
`timescale 1ns/100ps

module uart_transmitter (
    input  logic             Clock,
    input  logic             reset,
    uart_byte_if.transmitter bytes,
    output logic             serial_out
);
    import uart_io_pkg::*;

    typedef enum logic [1:0] {
        state_idle,
        state_start,
        state_data,
        state_stop
    } tx_state_t;

    tx_state_t  state;
    bit_count_t clock_count;
    logic [2:0] bit_index;
    byte_t      shift_reg;
    logic       bit_done;

    // Only accept a new byte between frames
    assign bytes.tx_ready = (state == state_idle);

    // Last cycle of the current bit period
    assign bit_done = (clock_count == bit_count_t'(CLOCKS_PER_BIT - 1));

    always_ff @(posedge Clock)
    begin
        if (reset || state == state_idle || bit_done)
            clock_count <= '0;
        else
            clock_count <= clock_count + 1'b1;
    end

    //----------------------------------------
    // Frame sequencing
    //----------------------------------------
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state      <= state_idle;
            serial_out <= 1'b1;
            bit_index  <= '0;
        end
        else
        begin
            case (state)
                state_idle:
                begin
                    if (bytes.tx_valid)
                    begin
                        state      <= state_start;
                        serial_out <= 1'b0;
                    end
                end
                state_start:
                begin
                    if (bit_done)
                    begin
                        state      <= state_data;
                        serial_out <= shift_reg[0];
                        bit_index  <= '0;
                    end
                end
                state_data:
                begin
                    if (bit_done)
                    begin
                        if (bit_index == 3'd7)
                        begin
                            state      <= state_stop;
                            serial_out <= 1'b1;
                        end
                        else
                        begin
                            serial_out <= shift_reg[0];
                            bit_index  <= bit_index + 1'b1;
                        end
                    end
                end
                state_stop:
                begin
                    if (bit_done)
                        state <= state_idle;
                end
                default:
                    state <= state_idle;
            endcase
        end
    end

    // LSB first, next bit always sits at position 0
    always_ff @(posedge Clock)
    begin
        if (state == state_idle && bytes.tx_valid)
            shift_reg <= bytes.tx_data;
        else if (bit_done && state != state_stop)
            shift_reg <= {1'b0, shift_reg[7:1]};
    end

endmodule

//--- sim.f
hdl/uart_io_pkg.sv
hdl/uart_byte_if.sv
hdl/uart_transmitter.sv
hdl/uart_receiver.sv
hdl/uart_mmio_bridge.sv
hdl/uart_io_top.sv
verification/tb_clock_gen.sv
verification/uart_io_assertions.sv
verification/uart_io_tb.sv

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic Clock,
    output logic reset
);

    localparam int HALF_PERIOD_NS = 20;
    localparam int RESET_CYCLES   = 10;

    initial
    begin
        Clock = 1'b0;
        forever
            #HALF_PERIOD_NS Clock = ~Clock;
    end

    // Released on a falling edge like every other input
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge Clock);
        @(negedge Clock);
        reset = 1'b0;
    end

endmodule

//--- verification/uart_io_assertions.sv
`timescale 1ns/100ps

module uart_io_assertions (
    input logic               Clock,
    input logic               reset,
    input logic               io_write,
    input uart_io_pkg::word_t read_data,
    input logic               serial_out
);
    import uart_io_pkg::*;

    localparam int FRAME_CLOCKS = 10 * CLOCKS_PER_BIT;

    int quiet_cycles;

    // Cycles since the last bus write, saturates at one frame
    always_ff @(posedge Clock)
    begin
        if (reset)
            quiet_cycles <= FRAME_CLOCKS;
        else if (io_write)
            quiet_cycles <= 0;
        else if (quiet_cycles < FRAME_CLOCKS)
            quiet_cycles <= quiet_cycles + 1;
    end

    line_idle_in_reset: assert property (@(posedge Clock) reset && $past(reset) |-> serial_out)
        else $error("serial_out low while reset is held");

    read_data_cleared: assert property (@(posedge Clock) $fell(reset) |-> read_data == '0)
        else $error("read_data not zero in the first cycle after reset");

    line_idle_without_write: assert property (@(posedge Clock) disable iff (reset)
        (quiet_cycles == FRAME_CLOCKS) |-> serial_out)
        else $error("serial_out low with no write during the last frame time");

endmodule

//--- verification/uart_io_tb.sv
`timescale 1ns/100ps

module uart_io_tb;
    import uart_io_pkg::*;

    localparam int    CLOCK_PERIOD_NS = 40;
    localparam int    FRAME_CLOCKS    = 10 * CLOCKS_PER_BIT;
    localparam int    TX_TESTS        = 8;
    localparam int    RX_TESTS        = 8;
    // Framing test takes three frame times and the duplex test one
    localparam int    TOTAL_FRAMES    = TX_TESTS + RX_TESTS + 4;
    localparam int    TIMEOUT_NS      = TOTAL_FRAMES * FRAME_CLOCKS * CLOCK_PERIOD_NS * 2;
    localparam word_t TX_READY_MASK   = word_t'(1) << STATUS_TX_READY_BIT;
    localparam word_t RX_VALID_MASK   = word_t'(1) << STATUS_RX_VALID_BIT;

    logic   Clock;
    logic   reset;
    word_t  addr;
    word_t  write_data;
    logic   io_write;
    logic   io_read;
    word_t  read_data;
    logic   serial_in;
    logic   serial_out;
    integer seed;
    byte_t  tx_expected[$];
    byte_t  tx_actual[$];
    int     tx_checked;

    tb_clock_gen i_tb_clock_gen (
        .Clock (Clock),
        .reset (reset)
    );

    uart_io_top i_uart_io_top (
        .Clock      (Clock),
        .reset      (reset),
        .addr       (addr),
        .write_data (write_data),
        .io_write   (io_write),
        .io_read    (io_read),
        .read_data  (read_data),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

    bind uart_io_top uart_io_assertions i_uart_io_assertions (
        .Clock      (Clock),
        .reset      (reset),
        .io_write   (io_write),
        .read_data  (read_data),
        .serial_out (serial_out)
    );

    //----------------------------------------
    // Reference model
    //----------------------------------------
    // Low two address bits name the byte lane
    function automatic byte_t expected_tx_byte(input word_t data, input word_t address);
        return byte_t'(data >> {address[1:0], 3'b000});
    endfunction

    function automatic word_t expected_status(input logic tx_ready, input logic rx_valid);
        return (word_t'(tx_ready) << STATUS_TX_READY_BIT)
             | (word_t'(rx_valid) << STATUS_RX_VALID_BIT);
    endfunction

    //----------------------------------------
    // Checks
    //----------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
            abort_run($sformatf("CHECK FAILED at %0d ns: %s expected %h actual %h",
                $time, name, expected, actual));
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected)
            abort_run($sformatf("CHECK FAILED at %0d ns: %s expected %h actual %h",
                $time, name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abort_run($sformatf("CHECK FAILED at %0d ns: %s expected %b actual %b",
                $time, name, expected, actual));
    endtask

    //----------------------------------------
    // Bus and serial line drivers
    //----------------------------------------
    task automatic bus_write(input word_t address, input word_t data);
        @(negedge Clock);
        addr       = address;
        write_data = data;
        io_write   = 1'b1;
        @(negedge Clock);
        io_write   = 1'b0;
    endtask

    // Read data is registered and valid one cycle later
    task automatic bus_read(input word_t address, output word_t data);
        @(negedge Clock);
        addr    = address;
        io_read = 1'b1;
        @(negedge Clock);
        io_read = 1'b0;
        data    = read_data;
    endtask

    task automatic poll_status(input word_t mask);
        word_t status;
        status = '0;
        while ((status & mask) == '0)
            bus_read(STATUS_ADDR, status);
    endtask

    task automatic drive_bit(input logic value);
        @(negedge Clock);
        serial_in = value;
        repeat (CLOCKS_PER_BIT - 1) @(negedge Clock);
    endtask

    task automatic send_frame(input byte_t data, input logic stop_bit);
        byte_t bits;
        bits = data;
        drive_bit(1'b0);
        repeat (8)
        begin
            drive_bit(bits[0]);
            bits = bits >> 1;
        end
        drive_bit(stop_bit);
        @(negedge Clock);
        serial_in = 1'b1;
    endtask

    task automatic pop_and_check(input byte_t data);
        word_t value;
        poll_status(RX_VALID_MASK);
        bus_read(RX_DATA_ADDR, value);
        check_word("read_data", {24'b0, data}, value);
    endtask

    task automatic wait_tx_frames(input int count);
        while (tx_checked < count)
            @(negedge Clock);
    endtask

    //----------------------------------------
    // serial_out monitor and compare
    //----------------------------------------
    // Samples near mid-bit on falling edges
    initial
    begin : serial_out_monitor
        byte_t frame;
        @(negedge reset);
        forever
        begin
            @(negedge serial_out);
            repeat (CLOCKS_PER_BIT / 2) @(negedge Clock);
            check_bit("serial_out start bit", 1'b0, serial_out);
            repeat (8)
            begin
                repeat (CLOCKS_PER_BIT) @(negedge Clock);
                frame = {serial_out, frame[7:1]};
            end
            repeat (CLOCKS_PER_BIT) @(negedge Clock);
            check_bit("serial_out stop bit", 1'b1, serial_out);
            tx_actual.push_back(frame);
        end
    end

    initial
    begin : tx_compare
        forever
        begin
            @(negedge Clock);
            while (tx_actual.size() > 0)
            begin
                if (tx_expected.size() == 0)
                    abort_run("serial_out sent a frame that no bus write asked for");
                else
                    check_byte("serial_out", tx_expected.pop_front(), tx_actual.pop_front());
                tx_checked++;
            end
        end
    end

    initial
    begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    //----------------------------------------
    // Stimulus
    //----------------------------------------
    initial
    begin : stimulus
        word_t rd;
        word_t status_before;
        word_t wr_word;
        word_t wr_addr;
        byte_t rx_byte;
        int    i;

        seed       = 22650;
        addr       = '0;
        write_data = '0;
        io_write   = 1'b0;
        io_read    = 1'b0;
        serial_in  = 1'b1;
        tx_checked = 0;
        @(negedge reset);

        // Idle state after reset
        bus_read(STATUS_ADDR, rd);
        check_word("read_data", expected_status(1'b1, 1'b0), rd);
        check_bit("serial_out", 1'b1, serial_out);

        // Transmit through every byte lane
        for (i = 0; i < TX_TESTS; i++)
        begin
            wr_word = word_t'($random(seed));
            wr_addr = TX_DATA_ADDR | word_t'(i[1:0]);
            poll_status(TX_READY_MASK);
            tx_expected.push_back(expected_tx_byte(wr_word, wr_addr));
            bus_write(wr_addr, wr_word);
        end
        wait_tx_frames(TX_TESTS);
        poll_status(TX_READY_MASK);

        // Receive where each read pops the held byte
        for (i = 0; i < RX_TESTS; i++)
        begin
            rx_byte = byte_t'($random(seed));
            send_frame(rx_byte, 1'b1);
            pop_and_check(rx_byte);
            bus_read(STATUS_ADDR, rd);
            check_word("read_data", expected_status(1'b1, 1'b0), rd);
        end

        // Empty receive register
        bus_read(STATUS_ADDR, status_before);
        check_word("read_data", expected_status(1'b1, 1'b0), status_before);
        bus_read(RX_DATA_ADDR, rd);
        check_word("read_data", '0, rd);
        bus_read(STATUS_ADDR, rd);
        check_word("read_data", status_before, rd);

        // Bad stop bit and a wait past the rx_valid deadline
        rx_byte = byte_t'($random(seed));
        send_frame(rx_byte, 1'b0);
        repeat (CLOCKS_PER_BIT) @(negedge Clock);
        bus_read(STATUS_ADDR, rd);
        check_word("read_data", expected_status(1'b1, 1'b0), rd);
        rx_byte = byte_t'($random(seed));
        send_frame(rx_byte, 1'b1);
        pop_and_check(rx_byte);

        // Full duplex
        wr_word = word_t'($random(seed));
        wr_addr = TX_DATA_ADDR | word_t'(2'd1);
        rx_byte = byte_t'($random(seed));
        fork
            begin
                poll_status(TX_READY_MASK);
                tx_expected.push_back(expected_tx_byte(wr_word, wr_addr));
                bus_write(wr_addr, wr_word);
            end
            send_frame(rx_byte, 1'b1);
        join
        pop_and_check(rx_byte);
        wait_tx_frames(TX_TESTS + 1);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
